//--- flist.f
+incdir+testbench
src/soc_pkg.sv
src/inst_bus_decoder.sv
src/data_bus_decoder.sv
src/dual_port_ram.sv
src/board_io_regs.sv
src/soc_top.sv
testbench/soc_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module soc_tb -f flist.f -o soc_sim || exit 1
out=$(./obj_dir/soc_sim)
echo "$out"
echo "$out" | grep -q "^TEST PASSED$" && echo "simulation ok" || { echo "simulation failed"; exit 1; }

//--- src/board_io_regs.sv
`timescale 1ns/1ps

module board_io_regs
  import soc_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n_i,

  input  logic                 io_stb_i,
  input  logic                 io_we_i,
  input  logic                 io_reg_sel_i,  // 1 selects keys
  input  logic [BUS_SEL_W-1:0] io_sel_i,
  input  bus_word_u            io_dat_i,
  output logic                 io_ack_o,
  output bus_word_u            io_dat_o,

  // board pins
  input  logic [KEY_W-1:0]     key_i,
  output logic [LED_W-1:0]     led_o
);

  logic [KEY_SYNC_STAGES-1:0][KEY_W-1:0] key_sync;
  logic [LED_W-1:0]                      led_q;
  bus_word_u                             rd_word;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      key_sync <= '0;
      led_q    <= '0;
      io_ack_o <= 1'b0;
    end
    else
    begin
      key_sync <= {key_sync[KEY_SYNC_STAGES-2:0], key_i};
      io_ack_o <= io_stb_i;
      // LED takes byte 0 only
      if (io_stb_i && io_we_i && !io_reg_sel_i && io_sel_i[0])
      begin
        led_q <= io_dat_i.bytes[0];
      end
    end
  end

  // read value, zeros above the register bits
  always_comb
  begin
    rd_word.word = '0;
    if (io_reg_sel_i)
    begin
      rd_word.word[KEY_W-1:0] = key_sync[KEY_SYNC_STAGES-1];
    end
    else
    begin
      rd_word.word[LED_W-1:0] = led_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if (io_stb_i)
    begin
      io_dat_o <= rd_word;
    end
  end

  assign led_o = led_q;

endmodule

//--- src/data_bus_decoder.sv
`timescale 1ns/1ps

module data_bus_decoder
  import soc_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,

  // data port
  input  logic                  data_stb_i,
  input  logic                  data_we_i,
  input  logic [BUS_ADDR_W-1:0] data_adr_i,
  input  logic [BUS_SEL_W-1:0]  data_sel_i,
  input  bus_word_u             data_dat_i,
  output logic                  data_ack_o,
  output logic                  data_err_o,
  output bus_word_u             data_dat_o,

  // RAM port B
  output logic                  ram_stb_o,
  output logic                  ram_we_o,
  output logic [RAM_ADDR_W-1:0] ram_idx_o,
  output logic [BUS_SEL_W-1:0]  ram_sel_o,
  output bus_word_u             ram_dat_o,
  input  logic                  ram_ack_i,
  input  bus_word_u             ram_dat_i,

  // board I/O registers
  output logic                  io_stb_o,
  output logic                  io_we_o,
  output logic                  io_reg_sel_o,
  output logic [BUS_SEL_W-1:0]  io_sel_o,
  output bus_word_u             io_dat_o,
  input  logic                  io_ack_i,
  input  bus_word_u             io_dat_i
);

  localparam int HI_LSB = RAM_ADDR_W + BYTE_OFS_W;

  logic ram_hit;
  logic led_hit;
  logic keys_hit;
  logic io_ok;      // LED access or key read
  logic tgt_ram_q;
  logic tgt_io_q;
  logic rd_q;       // response carries read data
  logic err_q;

  assign ram_hit  = (data_adr_i[BUS_ADDR_W-1:HI_LSB] == RAM_BASE[BUS_ADDR_W-1:HI_LSB]);
  assign led_hit  = (data_adr_i[BUS_ADDR_W-1:BYTE_OFS_W] == LED_ADDR[BUS_ADDR_W-1:BYTE_OFS_W]);
  assign keys_hit = (data_adr_i[BUS_ADDR_W-1:BYTE_OFS_W] == KEYS_ADDR[BUS_ADDR_W-1:BYTE_OFS_W]);

  // keys are read only
  assign io_ok = led_hit | (keys_hit & ~data_we_i);

  // RAM request
  assign ram_stb_o = data_stb_i & ram_hit;
  assign ram_we_o  = data_we_i;
  assign ram_idx_o = data_adr_i[HI_LSB-1:BYTE_OFS_W];
  assign ram_sel_o = data_sel_i;
  assign ram_dat_o = data_dat_i;

  // I/O request
  assign io_stb_o     = data_stb_i & io_ok;
  assign io_we_o      = data_we_i;
  assign io_reg_sel_o = data_adr_i[BYTE_OFS_W];  // word 1 of the I/O block is keys
  assign io_sel_o     = data_sel_i;
  assign io_dat_o     = data_dat_i;

  // remember who answers next cycle
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      tgt_ram_q <= 1'b0;
      tgt_io_q  <= 1'b0;
      rd_q      <= 1'b0;
      err_q     <= 1'b0;
    end
    else
    begin
      tgt_ram_q <= ram_stb_o;
      tgt_io_q  <= io_stb_o;
      rd_q      <= data_stb_i & ~data_we_i;
      err_q     <= data_stb_i & ~ram_hit & ~io_ok;  // unmapped or key write
    end
  end

  assign data_ack_o = (tgt_ram_q & ram_ack_i) | (tgt_io_q & io_ack_i);
  assign data_err_o = err_q;

  // read data from the recorded target, zero on writes
  always_comb
  begin
    data_dat_o.word = '0;
    if (rd_q)
    begin
      if (tgt_ram_q)
      begin
        data_dat_o = ram_dat_i;
      end
      else if (tgt_io_q)
      begin
        data_dat_o = io_dat_i;
      end
    end
  end

endmodule

//--- src/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram
  import soc_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,

  // port A, instruction reads
  input  logic                  a_stb_i,
  input  logic [RAM_ADDR_W-1:0] a_idx_i,
  output logic                  a_ack_o,
  output bus_word_u             a_dat_o,

  // port B, data reads and byte writes
  input  logic                  b_stb_i,
  input  logic                  b_we_i,
  input  logic [RAM_ADDR_W-1:0] b_idx_i,
  input  logic [BUS_SEL_W-1:0]  b_sel_i,
  input  bus_word_u             b_dat_i,
  output logic                  b_ack_o,
  output bus_word_u             b_dat_o
);

  bus_word_u mem [RAM_WORDS];

  // storage and read data
  always_ff @(posedge clk)
  begin
    if (a_stb_i)
    begin
      a_dat_o <= mem[a_idx_i];  // old word if B writes the same index
    end
    if (b_stb_i)
    begin
      b_dat_o <= mem[b_idx_i];
      if (b_we_i)
      begin
        for (int i = 0; i < BUS_SEL_W; i++)
        begin
          if (b_sel_i[i])
          begin
            mem[b_idx_i].bytes[i] <= b_dat_i.bytes[i];
          end
        end
      end
    end
  end

  // one cycle ack per port
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      a_ack_o <= 1'b0;
      b_ack_o <= 1'b0;
    end
    else
    begin
      a_ack_o <= a_stb_i;
      b_ack_o <= b_stb_i;
    end
  end

endmodule

//--- src/inst_bus_decoder.sv
`timescale 1ns/1ps

module inst_bus_decoder
  import soc_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,

  // instruction port
  input  logic                  inst_stb_i,
  input  logic [BUS_ADDR_W-1:0] inst_adr_i,
  output logic                  inst_ack_o,
  output logic                  inst_err_o,
  output bus_word_u             inst_dat_o,

  // RAM port A
  output logic                  ram_stb_o,
  output logic [RAM_ADDR_W-1:0] ram_idx_o,
  input  logic                  ram_ack_i,
  input  bus_word_u             ram_dat_i
);

  localparam int HI_LSB = RAM_ADDR_W + BYTE_OFS_W;  // first bit above the RAM window

  logic ram_hit;
  logic err_q;

  // RAM window is all upper bits matching the base
  assign ram_hit = (inst_adr_i[BUS_ADDR_W-1:HI_LSB] == RAM_BASE[BUS_ADDR_W-1:HI_LSB]);

  assign ram_stb_o = inst_stb_i & ram_hit;
  assign ram_idx_o = inst_adr_i[HI_LSB-1:BYTE_OFS_W];  // word index

  // anything outside the RAM answers with err next cycle
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      err_q <= 1'b0;
    end
    else
    begin
      err_q <= inst_stb_i & ~ram_hit;
    end
  end

  // RAM is the only target here
  assign inst_ack_o = ram_ack_i;
  assign inst_err_o = err_q;
  assign inst_dat_o = ram_dat_i;

endmodule

//--- src/soc_pkg.sv
package soc_pkg;

  // bus widths
  localparam int BUS_DATA_W = 32;
  localparam int BUS_ADDR_W = 32;
  localparam int BUS_SEL_W  = 4;
  localparam int BYTE_W     = 8;
  localparam int BYTE_OFS_W = 2;  // byte offset bits inside a word

  // shared RAM, word indexed
  localparam int RAM_ADDR_W = 10;  // 1k words, 4 KiB
  localparam int RAM_WORDS  = 2 ** RAM_ADDR_W;

  // address map
  localparam logic [BUS_ADDR_W-1:0] RAM_BASE  = 32'h0000_0000;
  localparam logic [BUS_ADDR_W-1:0] LED_ADDR  = 32'h8000_0000;
  localparam logic [BUS_ADDR_W-1:0] KEYS_ADDR = 32'h8000_0004;

  // board I/O
  localparam int LED_W = 8;
  localparam int KEY_W = 2;

  // response timing
  localparam int KEY_SYNC_STAGES = 2;  // edges from key pin to readable value

  // one bus word, seen whole or as byte lanes
  typedef union packed {
    logic [BUS_DATA_W-1:0]            word;
    logic [BUS_SEL_W-1:0][BYTE_W-1:0] bytes;
  } bus_word_u;

endpackage

//--- src/soc_top.sv
`timescale 1ns/1ps

module soc_top
  import soc_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,

  // instruction port
  input  logic                  inst_stb_i,
  input  logic [BUS_ADDR_W-1:0] inst_adr_i,
  output logic                  inst_ack_o,
  output logic                  inst_err_o,
  output bus_word_u             inst_dat_o,

  // data port
  input  logic                  data_stb_i,
  input  logic                  data_we_i,
  input  logic [BUS_ADDR_W-1:0] data_adr_i,
  input  logic [BUS_SEL_W-1:0]  data_sel_i,
  input  bus_word_u             data_dat_i,
  output logic                  data_ack_o,
  output logic                  data_err_o,
  output bus_word_u             data_dat_o,

  // board pins
  input  logic [KEY_W-1:0]      key_i,
  output logic [LED_W-1:0]      led_o
);

  // instruction decoder to RAM port A
  logic                  ram_a_stb;
  logic [RAM_ADDR_W-1:0] ram_a_idx;
  logic                  ram_a_ack;
  bus_word_u             ram_a_dat;

  // data decoder to RAM port B
  logic                  ram_b_stb;
  logic                  ram_b_we;
  logic [RAM_ADDR_W-1:0] ram_b_idx;
  logic [BUS_SEL_W-1:0]  ram_b_sel;
  bus_word_u             ram_b_wdat;
  logic                  ram_b_ack;
  bus_word_u             ram_b_dat;

  // data decoder to I/O block
  logic                  io_stb;
  logic                  io_we;
  logic                  io_reg_sel;
  logic [BUS_SEL_W-1:0]  io_sel;
  bus_word_u             io_dat;
  logic                  io_ack;
  bus_word_u             io_rdat;

  inst_bus_decoder inst_bus_decoder_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .inst_stb_i (inst_stb_i),
    .inst_adr_i (inst_adr_i),
    .inst_ack_o (inst_ack_o),
    .inst_err_o (inst_err_o),
    .inst_dat_o (inst_dat_o),
    .ram_stb_o  (ram_a_stb),
    .ram_idx_o  (ram_a_idx),
    .ram_ack_i  (ram_a_ack),
    .ram_dat_i  (ram_a_dat)
  );

  data_bus_decoder data_bus_decoder_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .data_stb_i   (data_stb_i),
    .data_we_i    (data_we_i),
    .data_adr_i   (data_adr_i),
    .data_sel_i   (data_sel_i),
    .data_dat_i   (data_dat_i),
    .data_ack_o   (data_ack_o),
    .data_err_o   (data_err_o),
    .data_dat_o   (data_dat_o),
    .ram_stb_o    (ram_b_stb),
    .ram_we_o     (ram_b_we),
    .ram_idx_o    (ram_b_idx),
    .ram_sel_o    (ram_b_sel),
    .ram_dat_o    (ram_b_wdat),
    .ram_ack_i    (ram_b_ack),
    .ram_dat_i    (ram_b_dat),
    .io_stb_o     (io_stb),
    .io_we_o      (io_we),
    .io_reg_sel_o (io_reg_sel),
    .io_sel_o     (io_sel),
    .io_dat_o     (io_dat),
    .io_ack_i     (io_ack),
    .io_dat_i     (io_rdat)
  );

  // shared by both decoders
  dual_port_ram dual_port_ram_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .a_stb_i (ram_a_stb),
    .a_idx_i (ram_a_idx),
    .a_ack_o (ram_a_ack),
    .a_dat_o (ram_a_dat),
    .b_stb_i (ram_b_stb),
    .b_we_i  (ram_b_we),
    .b_idx_i (ram_b_idx),
    .b_sel_i (ram_b_sel),
    .b_dat_i (ram_b_wdat),
    .b_ack_o (ram_b_ack),
    .b_dat_o (ram_b_dat)
  );

  board_io_regs board_io_regs_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .io_stb_i     (io_stb),
    .io_we_i      (io_we),
    .io_reg_sel_i (io_reg_sel),
    .io_sel_i     (io_sel),
    .io_dat_i     (io_dat),
    .io_ack_o     (io_ack),
    .io_dat_o     (io_rdat),
    .key_i        (key_i),
    .led_o        (led_o)
  );

endmodule

//--- testbench/soc_model.svh
`ifndef SOC_MODEL_SVH
`define SOC_MODEL_SVH

// expected DUT state
bus_word_u        ram_m [RAM_WORDS];
logic [LED_W-1:0] led_m;
logic [KEY_W-1:0] key_m;
int               key_age;  // cycles since the key pins last moved

function automatic logic is_ram(logic [BUS_ADDR_W-1:0] a);
  return (a >> (RAM_ADDR_W + 2)) == 0;  // nothing set above index and offset
endfunction

task automatic update_keys(input logic [KEY_W-1:0] k);
  key_age = (k == key_m) ? key_age + 1 : 0;
  key_m   = k;
endtask

// instruction side only reaches RAM and reads before the data side writes
task automatic predict_inst(input logic stb, input logic [BUS_ADDR_W-1:0] adr,
                            output logic ack, output logic err, output bus_word_u dat);
  ack = stb & is_ram(adr);
  err = stb & ~is_ram(adr);
  dat = ram_m[adr[RAM_ADDR_W+1:2]];
endtask

task automatic predict_data(input logic stb, input logic we,
                            input logic [BUS_ADDR_W-1:0] adr,
                            input logic [BUS_SEL_W-1:0] sel, input bus_word_u wdat,
                            output logic ack, output logic err, output bus_word_u dat);
  logic [BUS_DATA_W-1:0] mask;
  logic [RAM_ADDR_W-1:0] idx;
  mask     = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  idx      = adr[RAM_ADDR_W+1:2];
  ack      = stb;
  err      = 1'b0;
  dat.word = '0;  // writes answer with zero
  if (stb && is_ram(adr))
  begin
    if (we)
    begin
      ram_m[idx].word = (ram_m[idx].word & ~mask) | (wdat.word & mask);
    end
    else
    begin
      dat = ram_m[idx];
    end
  end
  else if (stb && (adr >> 2) == (LED_ADDR >> 2))
  begin
    if (!we)
    begin
      dat.word[LED_W-1:0] = led_m;
    end
    else if (sel[0])
    begin
      led_m = wdat.word[LED_W-1:0];  // low byte lane only
    end
  end
  else if (stb && (adr >> 2) == (KEYS_ADDR >> 2) && !we)
  begin
    dat.word[KEY_W-1:0] = key_m;
  end
  else if (stb)
  begin
    // unmapped, or a write to the read-only keys
    ack = 1'b0;
    err = 1'b1;
  end
endtask

`endif

//--- testbench/soc_tb.sv
`timescale 1ns/1ps

module soc_tb
  import soc_pkg::*;
();

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 5;
  localparam int TEST_CYCLES    = 2400;
  localparam int RANDOM_CYCLES  = TEST_CYCLES - 20;  // reset, idle, pool fill, drain
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

  logic                  clk;
  logic                  rst_n_i;
  logic                  inst_stb_i;
  logic [BUS_ADDR_W-1:0] inst_adr_i;
  logic                  inst_ack_o;
  logic                  inst_err_o;
  bus_word_u             inst_dat_o;
  logic                  data_stb_i;
  logic                  data_we_i;
  logic [BUS_ADDR_W-1:0] data_adr_i;
  logic [BUS_SEL_W-1:0]  data_sel_i;
  bus_word_u             data_dat_i;
  logic                  data_ack_o;
  logic                  data_err_o;
  bus_word_u             data_dat_o;
  logic [KEY_W-1:0]      key_i;
  logic [LED_W-1:0]      led_o;

  logic [15:0]      lfsr_q;
  logic [KEY_W-1:0] key_next;
  int               cycle_cnt = 0;
  logic             pend_ia, pend_ie, pend_da, pend_de;  // responses due at the next check
  bus_word_u        pend_idat;
  bus_word_u        pend_ddat;
  logic [LED_W-1:0] pend_led;

  `include "soc_model.svh"

  soc_top soc_top_inst (.*);

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // eight words spread over the RAM, both ports draw from them
  function automatic logic [BUS_ADDR_W-1:0] pool_addr(logic [2:0] k, logic [1:0] ofs);
    return {{(BUS_ADDR_W - RAM_ADDR_W - 2){1'b0}}, k, 4'b0101, k, ofs};
  endfunction

  task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("TEST FAILED");
    $fatal(1, "mismatch on %s", name);
  endtask

  task automatic compare_word(input string name, input bus_word_u got, input bus_word_u exp);
    if (got.word !== exp.word)
    begin
      fail_value(name, got.word, exp.word);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      fail_value(name, {31'd0, got}, {31'd0, exp});
    end
  endtask

  task automatic compare_leds(input logic [LED_W-1:0] got, input logic [LED_W-1:0] exp);
    if (got !== exp)
    begin
      fail_value("led_o", {24'd0, got}, {24'd0, exp});
    end
  endtask

  // one bus cycle: drive a request, then check the one before it
  task automatic issue(input logic i_stb, input logic [BUS_ADDR_W-1:0] i_adr,
                       input logic d_stb, input logic d_we, input logic [BUS_ADDR_W-1:0] d_adr,
                       input logic [BUS_SEL_W-1:0] d_sel, input logic [BUS_DATA_W-1:0] d_dat);
    logic      ia, ie, da, de;
    bus_word_u idat;
    bus_word_u ddat;
    bus_word_u wdat;
    wdat.word = d_dat;
    @(posedge clk);
    #1;
    predict_inst(i_stb, i_adr, ia, ie, idat);  // before the data write lands
    predict_data(d_stb, d_we, d_adr, d_sel, wdat, da, de, ddat);
    inst_stb_i      = i_stb;
    inst_adr_i      = i_adr;
    data_stb_i      = d_stb;
    data_we_i       = d_we;
    data_adr_i      = d_adr;
    data_sel_i      = d_sel;
    data_dat_i.word = d_dat;
    key_i           = key_m;
    @(negedge clk);
    compare_flag("inst_ack_o", inst_ack_o, pend_ia);
    compare_flag("inst_err_o", inst_err_o, pend_ie);
    compare_flag("data_ack_o", data_ack_o, pend_da);
    compare_flag("data_err_o", data_err_o, pend_de);
    compare_leds(led_o, pend_led);
    if (pend_ia)
    begin
      compare_word("inst_dat_o", inst_dat_o, pend_idat);
    end
    if (pend_da)
    begin
      compare_word("data_dat_o", data_dat_o, pend_ddat);
    end
    pend_ia   = ia;
    pend_ie   = ie;
    pend_da   = da;
    pend_de   = de;
    pend_idat = idat;
    pend_ddat = ddat;
    pend_led  = led_m;
  endtask

  task automatic random_cycle();
    logic [31:0]           r;
    logic                  i_stb;
    logic [BUS_ADDR_W-1:0] i_adr;
    logic                  d_stb;
    logic                  d_we;
    logic [BUS_ADDR_W-1:0] d_adr;
    logic [BUS_SEL_W-1:0]  d_sel;
    r = random_bits(5);
    if (r == 0)
    begin
      r        = random_bits(KEY_W);
      key_next = r[KEY_W-1:0];
    end
    update_keys(key_next);
    r     = random_bits(2);
    i_stb = (r != 0);
    r     = random_bits(7);  // kind, pool slot, byte offset
    i_adr = (r[1:0] == 2'b11) ? ((r[2] ? LED_ADDR : 32'h0000_1000) | {28'd0, r[6:3]})
                              : pool_addr(r[4:2], r[6:5]);
    r     = random_bits(2);
    d_stb = (r != 0);
    r     = random_bits(1);
    d_we  = r[0];
    r     = random_bits(BUS_SEL_W);
    d_sel = r[BUS_SEL_W-1:0];
    r     = random_bits(8);
    case (r[2:0])
      3'd4: d_adr = LED_ADDR | {30'd0, r[7:6]};
      3'd5: d_adr = KEYS_ADDR | {30'd0, r[7:6]};
      3'd6: d_adr = 32'h4000_0000 | {24'd0, r[7:0]};
      3'd7: d_adr = 32'h8000_0008 | {26'd0, r[7:3], 1'b0};  // just past the I/O words
      default: d_adr = pool_addr(r[5:3], r[7:6]);
    endcase
    if (r[2:0] == 3'd5 && !d_we && key_age < 3)
    begin
      d_we = 1'b1;  // synchronizer not settled yet, make it a key write
    end
    issue(i_stb, i_adr, d_stb, d_we, d_adr, d_sel, random_bits(32));
  endtask

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    lfsr_q          = 16'd90;
    rst_n_i         = 1'b0;
    inst_stb_i      = 1'b0;
    inst_adr_i      = '0;
    data_stb_i      = 1'b0;
    data_we_i       = 1'b0;
    data_adr_i      = '0;
    data_sel_i      = '0;
    data_dat_i.word = '0;
    key_i           = '0;
    key_next        = '0;
    key_m           = '0;
    key_age         = 100;
    led_m           = '0;
    {pend_ia, pend_ie, pend_da, pend_de} = '0;
    pend_led        = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    repeat (4) issue(1'b0, '0, 1'b0, 1'b0, '0, '0, '0);  // reset state, no strobes
    for (int k = 0; k < 8; k++)
    begin
      issue(1'b0, '0, 1'b1, 1'b1, pool_addr(k[2:0], 2'b00), 4'hf, random_bits(32));
    end
    for (int n = 0; n < RANDOM_CYCLES; n++)
    begin
      random_cycle();
    end
    issue(1'b0, '0, 1'b0, 1'b0, '0, '0, '0);
    $display("TEST PASSED");
    $finish;
  end

endmodule
